// ==== common/uart_hub_pkg.sv ====
// --------------------
// UART hub shared types
// --------------------
`default_nettype none

package uart_hub_pkg;

	// Channel count and index width
	localparam int NUM_CHANNELS = 4;
	localparam int CHAN_W = (NUM_CHANNELS > 1) ? $clog2(NUM_CHANNELS) : 1; // At least one bit

	// Frame format, no parity
	localparam int DATA_BITS = 8; // LSB first on the wire

	// Bit timing
	localparam int CLK_FREQ = 50_000_000;
	localparam int BAUD_RATE = 3_125_000; // Fast on purpose, keeps sims short
	localparam int CLKS_PER_BIT = CLK_FREQ / BAUD_RATE; // 16

	// One received frame, as a receiver reports it
	typedef struct packed {
		logic [DATA_BITS-1:0] data;
		logic frame_error; // Stop bit sampled low
	} rx_frame_t;

	// Merged output word, tagged with its source line
	typedef struct packed {
		logic [CHAN_W-1:0] channel;
		logic [DATA_BITS-1:0] data;
		logic frame_error;
	} rx_word_t;

endpackage

`default_nettype wire

// ==== verilog/line_conditioner.sv ====
// --------------------
// Serial line conditioner
// --------------------
`timescale 1ns/1ps
`default_nettype none

module line_conditioner (
	input logic clk,
	input logic sresetn,
	input logic [uart_hub_pkg::NUM_CHANNELS-1:0] serial_in, // Async, idles high
	output logic [uart_hub_pkg::NUM_CHANNELS-1:0] line_clean
);

	import uart_hub_pkg::*;

	logic [NUM_CHANNELS-1:0] sync_1; // First synchronizer stage, may go metastable
	logic [NUM_CHANNELS-1:0] sync_2;
	logic [NUM_CHANNELS-1:0] hist_1; // Older samples for the vote
	logic [NUM_CHANNELS-1:0] hist_2;
	logic [NUM_CHANNELS-1:0] vote;

	// Two out of three, bit by bit
	// A one-cycle glitch is outvoted by its neighbours
	assign vote = (sync_2 & hist_1) | (sync_2 & hist_2) | (hist_1 & hist_2);

	always_ff @(posedge clk) begin
		if (!sresetn) begin
			// Everything idles high
			sync_1 <= '1;
			sync_2 <= '1;
			hist_1 <= '1;
			hist_2 <= '1;
			line_clean <= '1;
		end else begin
			sync_1 <= serial_in;
			sync_2 <= sync_1;
			hist_1 <= sync_2; // Sample history shifts along
			hist_2 <= hist_1;
			line_clean <= vote; // Registered, 4 cycles pin to output
		end
	end

endmodule

`default_nettype wire

// ==== uart_rx/uart_rx.sv ====
// --------------------
// UART receiver
// --------------------
`timescale 1ns/1ps
`default_nettype none

// No parity, any number of stop bits
module uart_rx #(
	parameter int CLKS_PER_BIT = uart_hub_pkg::CLKS_PER_BIT,
	parameter int DATA_BITS = uart_hub_pkg::DATA_BITS
) (
	input logic clk,
	input logic sresetn,
	input logic line, // Already synchronized and filtered
	output logic frame_valid, // One-cycle strobe at mid stop bit
	output uart_hub_pkg::rx_frame_t frame
);

	localparam int BAUD_W = $clog2(CLKS_PER_BIT);
	localparam int BIT_W = $clog2(DATA_BITS + 2); // Start and stop bit counted too

	localparam logic [BAUD_W-1:0] BAUD_LAST = BAUD_W'(CLKS_PER_BIT - 1);
	localparam logic [BAUD_W-1:0] BAUD_MID = BAUD_W'(CLKS_PER_BIT / 2 - 1); // Sample point
	localparam logic [BIT_W-1:0] BIT_STOP = BIT_W'(DATA_BITS + 1);

	typedef enum logic [1:0] {
		ST_IDLE, // Waiting for a start bit
		ST_RECEIVE, // Start, data and stop bit
		ST_WAIT_IDLE // Hold off until the line is back high
	} state_t;

	state_t state;
	logic [BAUD_W-1:0] baud_ctr; // Clocks within the current bit
	logic [BIT_W-1:0] bit_ctr; // 0 is start bit, BIT_STOP is stop bit
	logic [DATA_BITS-1:0] shift_reg;

	logic mid_bit;
	logic start_bit;
	logic stop_bit;
	logic data_bit;

	assign mid_bit = (state == ST_RECEIVE) && (baud_ctr == BAUD_MID);
	assign start_bit = (bit_ctr == '0);
	assign stop_bit = (bit_ctr == BIT_STOP);
	assign data_bit = !start_bit && !stop_bit;

	// Control path
	always_ff @(posedge clk) begin
		if (!sresetn) begin
			state <= ST_IDLE;
			baud_ctr <= '0;
			bit_ctr <= '0;
			frame_valid <= 1'b0;
		end else begin
			frame_valid <= 1'b0; // Strobe by default low

			case (state)
				ST_IDLE: begin
					// The low cycle seen here counts as clock 0 of the start bit
					baud_ctr <= BAUD_W'(1);
					bit_ctr <= '0;
					if (!line)
						state <= ST_RECEIVE;
				end

				ST_RECEIVE: begin
					if (baud_ctr == BAUD_LAST) begin // Next bit period
						baud_ctr <= '0;
						bit_ctr <= bit_ctr + 1'b1;
					end else begin
						baud_ctr <= baud_ctr + 1'b1;
					end

					if (mid_bit) begin
						if (start_bit) begin
							if (line)
								state <= ST_IDLE; // Gone high again, false start
						end else if (stop_bit) begin
							frame_valid <= 1'b1;
							state <= ST_WAIT_IDLE;
						end
					end
				end

				ST_WAIT_IDLE: begin
					// A low stop bit leaves us here until the line recovers
					if (line)
						state <= ST_IDLE;
				end

				default: state <= ST_IDLE;
			endcase
		end
	end

	// Data path
	always_ff @(posedge clk) begin
		if (mid_bit && data_bit)
			shift_reg <= {line, shift_reg[DATA_BITS-1:1]}; // LSB arrives first
		if (mid_bit && stop_bit) begin
			frame.data <= shift_reg;
			frame.frame_error <= !line; // Stop bit must be high
		end
	end

endmodule

`default_nettype wire

// ==== verilog/rx_collector.sv ====
// --------------------
// Frame collector
// --------------------
`timescale 1ns/1ps
`default_nettype none

// Merges per-channel frames into one tagged stream
module rx_collector (
	input logic clk,
	input logic sresetn,
	input logic [uart_hub_pkg::NUM_CHANNELS-1:0] frame_valid,
	input uart_hub_pkg::rx_frame_t frame [uart_hub_pkg::NUM_CHANNELS],
	output logic out_valid, // One-cycle strobe
	output uart_hub_pkg::rx_word_t out_word
);

	import uart_hub_pkg::*;

	localparam logic [CHAN_W-1:0] LAST_CHAN = CHAN_W'(NUM_CHANNELS - 1);

	rx_frame_t hold_q [NUM_CHANNELS]; // One frame per channel
	logic [NUM_CHANNELS-1:0] pending; // Holding register full, not yet sent
	logic [CHAN_W-1:0] rr_ptr; // Search starts here

	logic sel_found;
	logic [CHAN_W-1:0] sel_idx;
	logic [NUM_CHANNELS-1:0] served;
	logic [CHAN_W-1:0] next_ptr;

	// First pending channel at or after the pointer
	always_comb begin
		int cand;
		sel_found = 1'b0;
		sel_idx = '0;
		for (int k = 0; k < NUM_CHANNELS; k++) begin
			cand = (int'(rr_ptr) + k) % NUM_CHANNELS; // Wraps for any channel count
			if (!sel_found && pending[cand]) begin
				sel_found = 1'b1;
				sel_idx = CHAN_W'(cand);
			end
		end
	end

	// One-hot of the channel sent this cycle
	always_comb begin
		served = '0;
		if (sel_found)
			served[sel_idx] = 1'b1;
	end

	// Pointer moves just past the winner
	assign next_ptr = (sel_idx == LAST_CHAN) ? '0 : sel_idx + 1'b1;

	// Control
	always_ff @(posedge clk) begin
		if (!sresetn) begin
			pending <= '0;
			rr_ptr <= '0;
			out_valid <= 1'b0;
		end else begin
			// A new frame sets its mark, a send clears it
			pending <= (pending & ~served) | frame_valid;
			out_valid <= sel_found;
			if (sel_found)
				rr_ptr <= next_ptr;
		end
	end

	// Holding registers
	// Receivers cannot refill a channel before it drains
	always_ff @(posedge clk) begin
		for (int i = 0; i < NUM_CHANNELS; i++) begin
			if (frame_valid[i])
				hold_q[i] <= frame[i];
		end
	end

	// Output word, tagged with its channel
	always_ff @(posedge clk) begin
		if (sel_found) begin
			out_word.channel <= sel_idx;
			out_word.data <= hold_q[sel_idx].data;
			out_word.frame_error <= hold_q[sel_idx].frame_error;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/uart_rx_hub.sv ====
// --------------------
// UART receive hub top
// --------------------
`timescale 1ns/1ps
`default_nettype none

// Conditioner, one receiver per line, then the collector
module uart_rx_hub (
	input logic clk,
	input logic sresetn,
	input logic [uart_hub_pkg::NUM_CHANNELS-1:0] serial_in, // Async lines, idle high
	output logic out_valid,
	output uart_hub_pkg::rx_word_t out_word
);

	import uart_hub_pkg::*;

	logic [NUM_CHANNELS-1:0] line_clean; // Synced, deglitched
	logic [NUM_CHANNELS-1:0] frame_valid; // Per-receiver strobes
	rx_frame_t frame [NUM_CHANNELS];

	// Sync and glitch filter for all lines
	line_conditioner u_cond (
		.clk (clk),
		.sresetn (sresetn),
		.serial_in (serial_in),
		.line_clean (line_clean)
	);

	// One receiver per line
	for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_rx
		uart_rx #(
			.CLKS_PER_BIT (CLKS_PER_BIT),
			.DATA_BITS (DATA_BITS)
		) u_rx (
			.clk (clk),
			.sresetn (sresetn),
			.line (line_clean[i]),
			.frame_valid (frame_valid[i]),
			.frame (frame[i])
		);
	end

	// Round-robin merge into one stream
	rx_collector u_collect (
		.clk (clk),
		.sresetn (sresetn),
		.frame_valid (frame_valid),
		.frame (frame),
		.out_valid (out_valid),
		.out_word (out_word)
	);

endmodule

`default_nettype wire

// ==== bench/uart_rx_hub_assert.sv ====
// --------------------
// Hub assertions
// --------------------
`timescale 1ns/1ps
`default_nettype none

module uart_rx_hub_assert (
	input logic clk,
	input logic sresetn,
	input logic [uart_hub_pkg::NUM_CHANNELS-1:0] frame_valid,
	input logic out_valid,
	input uart_hub_pkg::rx_word_t out_word
);

	import uart_hub_pkg::*;

	// Output register cleared by reset
	a_quiet_in_reset: assert property (@(posedge clk) !sresetn |=> !out_valid)
		else $error("out_valid high during reset");

	a_channel_range: assert property (@(posedge clk) disable iff (!sresetn)
		out_valid |-> (int'(out_word.channel) < NUM_CHANNELS))
		else $error("out_word.channel out of range");

	// Back-to-back words must come from different channels
	a_no_double: assert property (@(posedge clk) disable iff (!sresetn)
		(out_valid && $past(out_valid)) |-> (out_word.channel != $past(out_word.channel)))
		else $error("out_valid held two cycles for one channel");

	// A holding register stays pending at most NUM_CHANNELS cycles
	for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_chan
		for (genvar k = 1; k <= NUM_CHANNELS; k++) begin : g_gap
			a_no_overwrite: assert property (@(posedge clk) disable iff (!sresetn)
				frame_valid[i] |-> !$past(frame_valid[i], k))
				else $error("Channel %0d refilled while pending", i);
		end
	end

endmodule

bind uart_rx_hub uart_rx_hub_assert u_assert (
	.clk (clk),
	.sresetn (sresetn),
	.frame_valid (frame_valid),
	.out_valid (out_valid),
	.out_word (out_word)
);

`default_nettype wire

// ==== bench/tb_uart_rx_hub.sv ====
// --------------------
// UART hub testbench
// --------------------
`timescale 1ns/1ps
`default_nettype none

module tb_uart_rx_hub;

	import uart_hub_pkg::*;

	localparam int SEED = 32'h4d56;
	localparam int RESET_CYCLES = 8;
	// Sync and filter, receiver to mid stop bit, collector
	localparam int MIN_LAT = 4 + (DATA_BITS + 1) * CLKS_PER_BIT + CLKS_PER_BIT / 2 + 2;
	localparam int MAX_LAT = MIN_LAT + NUM_CHANNELS - 1; // Worst round-robin wait
	localparam int NUM_RANDOM = 40;
	localparam int WORD_WAIT = 400; // Cycles allowed for one awaited word
	localparam int TIMEOUT_CYCLES = 20000; // About 60 frames of ~170 cycles, plus margin

	logic clk;
	logic sresetn;
	logic [NUM_CHANNELS-1:0] serial_in;
	logic out_valid;
	rx_word_t out_word;

	int cycle;
	int start_cyc [NUM_CHANNELS]; // Cycle of each line's last start edge
	rx_word_t words [$]; // Everything seen on the output
	int word_cyc [$];

	// Random traffic table
	int rnd_chan [NUM_RANDOM];
	logic [DATA_BITS-1:0] rnd_data [NUM_RANDOM];
	int rnd_stop [NUM_RANDOM];
	int rnd_gap [NUM_RANDOM];

	uart_rx_hub uut (
		.clk (clk),
		.sresetn (sresetn),
		.serial_in (serial_in),
		.out_valid (out_valid),
		.out_word (out_word)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk; // 10 ns period
	end

	// Cycle count and run limit
	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= TIMEOUT_CYCLES)
			fail_run($sformatf("Run went past the limit of %0d cycles", TIMEOUT_CYCLES));
	end

	// Output monitor, samples mid-cycle
	always @(negedge clk) begin
		if (out_valid === 1'b1) begin
			words.push_back(out_word);
			word_cyc.push_back(cycle);
		end
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input rx_word_t exp, input rx_word_t got);
		if (got !== exp)
			fail_run($sformatf("[FAIL] %s: expected 0x%h, got 0x%h", name, exp, got));
	endtask

	task automatic check_count(input string name, input int exp, input int got);
		if (got != exp)
			fail_run($sformatf("[FAIL] %s: expected 0x%h, got 0x%h", name, exp, got));
	endtask

	function automatic rx_word_t make_word(input int ch, input logic [DATA_BITS-1:0] data,
			input logic err);
		rx_word_t w;
		w.channel = CHAN_W'(ch);
		w.data = data;
		w.frame_error = err;
		return w;
	endfunction

	task automatic idle(input int n);
		repeat (n) @(negedge clk);
	endtask

	task automatic clear_words();
		words.delete();
		word_cyc.delete();
	endtask

	// One bit time on one line, entered and left on a falling edge
	task automatic drive_bit(input int ch, input logic level);
		serial_in[ch] = level;
		repeat (CLKS_PER_BIT) @(negedge clk);
	endtask

	// One low clock on an idle line
	task automatic pulse_low(input int ch);
		serial_in[ch] = 1'b0;
		@(negedge clk);
		serial_in[ch] = 1'b1;
	endtask

	// Start bit, data LSB first, then the stop bits at the chosen level
	task automatic send_frame(input int ch, input logic [DATA_BITS-1:0] data,
			input logic stop_level, input int stop_bits);
		@(negedge clk);
		start_cyc[ch] = cycle;
		drive_bit(ch, 1'b0);
		for (int b = 0; b < DATA_BITS; b++)
			drive_bit(ch, data[b]);
		for (int s = 0; s < stop_bits; s++)
			drive_bit(ch, stop_level);
		serial_in[ch] = 1'b1; // Line back to idle
	endtask

	task automatic wait_words(input int n);
		int waited;
		waited = 0;
		while (words.size() < n) begin
			@(negedge clk);
			waited++;
			if (waited > WORD_WAIT)
				fail_run($sformatf("Word %0d of %0d did not arrive within %0d cycles",
					words.size() + 1, n, WORD_WAIT));
		end
	endtask

	// Words of one channel, in arrival order, against the expected bytes
	task automatic check_channel(input int ch, input logic [DATA_BITS-1:0] exp_data [$]);
		rx_word_t got [$];
		foreach (words[k])
			if (int'(words[k].channel) == ch)
				got.push_back(words[k]);
		check_count($sformatf("channel %0d words", ch), exp_data.size(), got.size());
		foreach (exp_data[j])
			check_word("out_word", make_word(ch, exp_data[j], 1'b0), got[j]);
	endtask

	task automatic run_lane(input int ch);
		for (int k = 0; k < NUM_RANDOM; k++) begin
			if (rnd_chan[k] == ch) begin
				send_frame(ch, rnd_data[k], 1'b1, rnd_stop[k]);
				idle(rnd_gap[k]);
			end
		end
	endtask

	task automatic test_single_byte();
		logic [DATA_BITS-1:0] data;
		int lat;
		for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
			clear_words();
			data = DATA_BITS'(32'h5A + 32'h33 * ch);
			send_frame(ch, data, 1'b1, 1);
			wait_words(1);
			idle(2 * CLKS_PER_BIT); // Room for a stray second word
			check_count("out_valid words", 1, words.size());
			check_word("out_word", make_word(ch, data, 1'b0), words[0]);
			lat = word_cyc[0] - start_cyc[ch];
			if (lat < MIN_LAT || lat > MAX_LAT)
				fail_run($sformatf("Channel %0d word latency %0d, expected %0d to %0d",
					ch, lat, MIN_LAT, MAX_LAT));
		end
	endtask

	task automatic test_simultaneous();
		logic [DATA_BITS-1:0] data [NUM_CHANNELS];
		logic [DATA_BITS-1:0] exp [$];
		int first;
		int last;
		for (int ch = 0; ch < NUM_CHANNELS; ch++)
			data[ch] = DATA_BITS'(32'hC1 + 32'h17 * ch);
		clear_words();
		for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
			fork
				automatic int c = ch;
				send_frame(c, data[c], 1'b1, 1); // All start on the same edge
			join_none
		end
		wait fork;
		wait_words(NUM_CHANNELS);
		idle(2 * CLKS_PER_BIT);
		check_count("out_valid words", NUM_CHANNELS, words.size());
		first = word_cyc[0];
		last = word_cyc[0];
		foreach (word_cyc[k]) begin
			first = (word_cyc[k] < first) ? word_cyc[k] : first;
			last = (word_cyc[k] > last) ? word_cyc[k] : last;
		end
		if (last - first > NUM_CHANNELS)
			fail_run($sformatf("Simultaneous words spread over %0d cycles", last - first));
		for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
			exp.delete();
			exp.push_back(data[ch]);
			check_channel(ch, exp);
		end
	endtask

	task automatic test_framing_error();
		clear_words();
		send_frame(1, 8'hA5, 1'b0, 3); // Stop held low for three bit times
		wait_words(1);
		idle(CLKS_PER_BIT);
		send_frame(1, 8'h3C, 1'b1, 1); // Only taken if the receiver re-armed
		wait_words(2);
		idle(2 * CLKS_PER_BIT);
		check_count("out_valid words", 2, words.size());
		check_word("out_word", make_word(1, 8'hA5, 1'b1), words[0]);
		check_word("out_word", make_word(1, 8'h3C, 1'b0), words[1]);
	endtask

	task automatic test_glitch();
		clear_words();
		@(negedge clk);
		pulse_low(0); // Would open a frame if it got through
		idle(CLKS_PER_BIT / 2 - 2);
		for (int b = 0; b <= DATA_BITS + 1; b++) begin
			pulse_low(0); // Lands on each mid-bit sample point
			idle(CLKS_PER_BIT - 1);
		end
		idle(CLKS_PER_BIT);
		serial_in[2] = 1'b0; // Passes the filter, gone by mid start bit
		idle(CLKS_PER_BIT / 2 - 3);
		serial_in[2] = 1'b1;
		idle(200);
		check_count("out_valid words", 0, words.size());
	endtask

	task automatic test_reset();
		clear_words();
		fork
			send_frame(0, 8'hFE, 1'b1, 1); // Line stays high after bit 0
			begin
				idle(3 * CLKS_PER_BIT); // Receiver is mid-frame here
				sresetn = 1'b0;
				idle(RESET_CYCLES);
				sresetn = 1'b1;
			end
		join
		idle(200);
		check_count("out_valid words", 0, words.size());
		send_frame(0, 8'hC3, 1'b1, 1); // Same line as the cut frame
		wait_words(1);
		idle(2 * CLKS_PER_BIT);
		check_count("out_valid words", 1, words.size());
		check_word("out_word", make_word(0, 8'hC3, 1'b0), words[0]);
	endtask

	task automatic test_random();
		logic [DATA_BITS-1:0] exp [$];
		for (int k = 0; k < NUM_RANDOM; k++) begin
			rnd_chan[k] = int'($urandom_range(NUM_CHANNELS - 1, 0));
			rnd_data[k] = DATA_BITS'($urandom);
			rnd_stop[k] = int'($urandom_range(3, 1));
			rnd_gap[k] = int'($urandom_range(20, 0));
		end
		clear_words();
		for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
			fork
				automatic int c = ch;
				run_lane(c); // Lanes overlap in time
			join_none
		end
		wait fork;
		wait_words(NUM_RANDOM);
		idle(2 * CLKS_PER_BIT);
		check_count("out_valid words", NUM_RANDOM, words.size());
		for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
			exp.delete();
			for (int k = 0; k < NUM_RANDOM; k++)
				if (rnd_chan[k] == ch)
					exp.push_back(rnd_data[k]);
			check_channel(ch, exp);
		end
	endtask

	initial begin
		void'($urandom(SEED));
		sresetn = 1'b0;
		serial_in = '1; // Lines idle high
		repeat (RESET_CYCLES) @(negedge clk);
		sresetn = 1'b1;
		idle(4);
		test_single_byte();
		test_simultaneous();
		test_framing_error();
		test_glitch();
		test_random();
		test_reset();
		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
common/uart_hub_pkg.sv
verilog/line_conditioner.sv
uart_rx/uart_rx.sv
verilog/rx_collector.sv
verilog/uart_rx_hub.sv
bench/uart_rx_hub_assert.sv
bench/tb_uart_rx_hub.sv

// ==== Makefile ====
# Verilator flow for the UART receive hub

VERILATOR ?= verilator
TOP ?= tb_uart_rx_hub
RTL_TOP ?= uart_rx_hub
FILELIST ?= src.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --timing --assert --timescale 1ns/1ps
LINT_FLAGS ?= -Wall

SRCS := $(shell cat $(FILELIST))
RTL_SRCS := $(filter-out bench/%,$(SRCS))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

sim: $(SIM_BIN)
	-./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
		echo "Failure reported, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "Simulation passed" $(LOG); then \
		echo "Run ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
